//--- verilog/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // ##############################
    // AXI4 channel payloads
    // ##############################

    typedef struct packed {
        addr_t      addr;
        logic [3:0] id;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        word_t      data;
        logic [1:0] resp;
        logic       last;
        logic [3:0] id;
    } axi_r_t;

    typedef struct packed {
        addr_t      addr;
        logic [3:0] id;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_aw_t;

    typedef struct packed {
        word_t      data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
        logic [3:0] id;
    } axi_b_t;

    // a single load or store from the core side.
    typedef struct packed {
        addr_t      addr;
        word_t      wdata;
        logic [3:0] wstrb;
        logic       write;
    } dmem_req_t;

    localparam logic [1:0] resp_okay = 2'b00;

    // the timer occupies one 64 KiB region of the data space.
    localparam addr_t       clint_base      = 32'h0200_0000;
    localparam logic [15:0] mtime_lo_offset = 16'hBFF8;
    localparam logic [15:0] mtime_hi_offset = 16'hBFFC;

endpackage

//--- verilog/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int cache_blocks = 16,
    parameter int block_bytes  = 16
) (
    input  logic           clock,
    input  logic           arst_n,
    input  logic           fetch_valid,
    input  mem_pkg::addr_t fetch_addr,
    output logic           fetch_ready,
    output logic           fetch_resp_valid,
    output logic           fetch_fault,
    output mem_pkg::word_t fetch_data,
    input  logic           flush,
    output logic           refill_req,
    output mem_pkg::addr_t refill_addr,
    input  logic           refill_beat_valid,
    input  logic           refill_done,
    input  logic           refill_fault,
    input  mem_pkg::word_t refill_beat
);
    import mem_pkg::*;

    localparam int words_per_block = block_bytes / 4;
    localparam int offset_bits     = $clog2(block_bytes);
    localparam int word_bits       = $clog2(words_per_block);
    localparam int index_bits      = $clog2(cache_blocks);
    localparam int tag_bits        = 32 - offset_bits - index_bits;

    typedef enum logic [1:0] {s_idle, s_lookup, s_refill, s_respond} state_t;

    state_t                  state;
    addr_t                   req_addr;
    logic                    fault_q;
    logic [word_bits-1:0]    beat_cnt;
    logic [cache_blocks-1:0] line_valid;
    logic [tag_bits-1:0]     tag_mem [cache_blocks];
    word_t                   data_mem [cache_blocks * words_per_block];

    logic [tag_bits-1:0]     req_tag;
    logic [index_bits-1:0]   req_idx;
    logic [word_bits-1:0]    req_word;
    logic                    hit;

    assign req_tag  = req_addr[31 -: tag_bits];
    assign req_idx  = req_addr[offset_bits +: index_bits];
    assign req_word = req_addr[2 +: word_bits];
    assign hit      = line_valid[req_idx] && (tag_mem[req_idx] == req_tag);

    // ##############################
    // fetch sequencing
    // ##############################

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= s_idle;
            fault_q  <= 1'b0;
            beat_cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (fetch_valid) begin
                        state <= s_lookup;
                    end
                end
                s_lookup: begin
                    if (hit) begin
                        state <= s_idle;
                    end else begin
                        beat_cnt <= '0;
                        state    <= s_refill;
                    end
                end
                s_refill: begin
                    if (refill_beat_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;  // beats arrive in address order.
                    end
                    if (refill_done) begin
                        fault_q <= refill_fault;
                        state   <= s_respond;
                    end
                end
                s_respond: state <= s_idle;
                default:   state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (fetch_valid && fetch_ready) begin
            req_addr <= fetch_addr;
        end
    end

    // a missing line is dropped before the refill, so a faulted refill leaves it invalid.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            line_valid <= '0;
        end else if (flush) begin
            line_valid <= '0;
        end else if (state == s_lookup && !hit) begin
            line_valid[req_idx] <= 1'b0;
        end else if (state == s_refill && refill_done && !refill_fault) begin
            line_valid[req_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (state == s_refill && refill_beat_valid) begin
            data_mem[{req_idx, beat_cnt}] <= refill_beat;
        end
        if (state == s_refill && refill_done) begin
            tag_mem[req_idx] <= req_tag;
        end
    end

    assign fetch_ready      = state == s_idle;
    assign fetch_resp_valid = (state == s_lookup && hit) || state == s_respond;
    assign fetch_data       = data_mem[{req_idx, req_word}];
    assign fetch_fault      = state == s_respond && fault_q;

    assign refill_req  = state == s_refill;
    assign refill_addr = {req_tag, req_idx, {offset_bits{1'b0}}};  // block aligned.

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int block_bytes = 16
) (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               data_valid,
    input  mem_pkg::dmem_req_t data_req,
    output logic               data_ready,
    output logic               data_resp_valid,
    output logic               data_fault,
    output mem_pkg::word_t     data_rdata,
    input  logic               refill_req,
    input  mem_pkg::addr_t     refill_addr,
    output logic               refill_beat_valid,
    output logic               refill_done,
    output logic               refill_fault,
    output mem_pkg::word_t     refill_beat,
    output logic               clint_rd,
    output logic [15:0]        clint_offset,
    input  logic               clint_rvalid,
    input  mem_pkg::word_t     clint_rdata,
    output mem_pkg::axi_ar_t   ar,
    output logic               arvalid,
    input  logic               arready,
    input  mem_pkg::axi_r_t    r,
    input  logic               rvalid,
    output logic               rready,
    output mem_pkg::axi_aw_t   aw,
    output logic               awvalid,
    input  logic               awready,
    output mem_pkg::axi_w_t    w,
    output logic               wvalid,
    input  logic               wready,
    input  mem_pkg::axi_b_t    b,
    input  logic               bvalid,
    output logic               bready
);
    import mem_pkg::*;

    localparam int         words_per_block = block_bytes / 4;
    localparam logic [1:0] burst_incr      = 2'b01;
    localparam logic [2:0] size_word       = 3'b010;

    typedef enum logic [2:0] {s_idle, s_clint, s_ar, s_r, s_aw_w, s_b} state_t;

    state_t    state;
    dmem_req_t req_q;
    logic      serve_refill;  // the running transaction belongs to the icache.
    logic      beat_fault;
    logic      aw_done;
    logic      w_done;
    logic      in_clint;

    assign in_clint   = data_req.addr[31:16] == clint_base[31:16];
    assign data_ready = state == s_idle;

    // ##############################
    // arbitration and sequencing
    // ##############################

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state        <= s_idle;
            serve_refill <= 1'b0;
            beat_fault   <= 1'b0;
            aw_done      <= 1'b0;
            w_done       <= 1'b0;
            clint_rd     <= 1'b0;
        end else begin
            clint_rd <= 1'b0;
            case (state)
                s_idle: begin
                    // data beats refill when both wait.
                    if (data_valid) begin
                        serve_refill <= 1'b0;
                        if (in_clint) begin
                            clint_rd <= 1'b1;  // a store here only waits out the read.
                            state    <= s_clint;
                        end else if (data_req.write) begin
                            aw_done <= 1'b0;
                            w_done  <= 1'b0;
                            state   <= s_aw_w;
                        end else begin
                            state <= s_ar;
                        end
                    end else if (refill_req) begin
                        serve_refill <= 1'b1;
                        beat_fault   <= 1'b0;
                        state        <= s_ar;
                    end
                end
                s_clint: begin
                    if (clint_rvalid) begin
                        state <= s_idle;
                    end
                end
                s_ar: begin
                    if (arready) begin
                        state <= s_r;
                    end
                end
                s_r: begin
                    if (rvalid) begin
                        beat_fault <= beat_fault | (r.resp != resp_okay);
                        if (!serve_refill || r.last) begin
                            state <= s_idle;
                        end
                    end
                end
                s_aw_w: begin
                    aw_done <= aw_done | awready;
                    w_done  <= w_done | wready;
                    if ((aw_done || awready) && (w_done || wready)) begin
                        state <= s_b;
                    end
                end
                s_b: begin
                    if (bvalid) begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (data_valid && data_ready) begin
            req_q <= data_req;
        end
    end

    assign clint_offset = req_q.addr[15:0];

    always_comb begin
        ar.addr  = serve_refill ? refill_addr : req_q.addr;
        ar.id    = serve_refill ? 4'd0 : 4'd1;
        ar.len   = serve_refill ? 8'(words_per_block - 1) : 8'd0;
        ar.size  = size_word;
        ar.burst = burst_incr;
    end

    assign aw = '{addr: req_q.addr, id: 4'd1, len: 8'd0, size: size_word, burst: burst_incr};
    assign w  = '{data: req_q.wdata, strb: req_q.wstrb, last: 1'b1};

    assign arvalid = state == s_ar;
    assign rready  = state == s_r;
    assign awvalid = state == s_aw_w && !aw_done;
    assign wvalid  = state == s_aw_w && !w_done;
    assign bready  = state == s_b;

    assign refill_beat_valid = state == s_r && rvalid && serve_refill;
    assign refill_beat       = r.data;
    assign refill_done       = refill_beat_valid && r.last;
    assign refill_fault      = refill_done && (beat_fault || r.resp != resp_okay);

    assign data_resp_valid = (state == s_clint && clint_rvalid)
                           || (state == s_r && rvalid && !serve_refill)
                           || (state == s_b && bvalid);
    assign data_rdata      = (state == s_clint) ? clint_rdata : r.data;
    assign data_fault      = (state == s_r && rvalid && !serve_refill && r.resp != resp_okay)
                           || (state == s_b && bvalid && b.resp != resp_okay);

endmodule

//--- verilog/clint.sv
`timescale 1ns/1ps

module clint (
    input  logic           clock,
    input  logic           arst_n,
    input  logic           rd,
    input  logic [15:0]    offset,
    output logic           rvalid,
    output mem_pkg::word_t rdata
);
    import mem_pkg::*;

    logic [63:0] mtime;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mtime  <= '0;
            rvalid <= 1'b0;
        end else begin
            mtime  <= mtime + 64'd1;  // free running, one tick per clock.
            rvalid <= rd;
        end
    end

    // the two halves are read separately, so a carry between reads is visible.
    always_ff @(posedge clock) begin
        if (rd) begin
            case (offset)
                mtime_lo_offset: rdata <= mtime[31:0];
                mtime_hi_offset: rdata <= mtime[63:32];
                default:         rdata <= '0;
            endcase
        end
    end

endmodule

//--- verilog/core_mem_system.sv
`timescale 1ns/1ps

module core_mem_system #(
    parameter int cache_blocks = 16,
    parameter int block_bytes  = 16
) (
    input  logic               clock,
    input  logic               arst_n,
    input  logic               fetch_valid,
    input  mem_pkg::addr_t     fetch_addr,
    output logic               fetch_ready,
    output logic               fetch_resp_valid,
    output logic               fetch_fault,
    output mem_pkg::word_t     fetch_data,
    input  logic               icache_flush,
    input  logic               data_valid,
    input  mem_pkg::dmem_req_t data_req,
    output logic               data_ready,
    output logic               data_resp_valid,
    output logic               data_fault,
    output mem_pkg::word_t     data_rdata,
    output mem_pkg::axi_ar_t   ar,
    output logic               arvalid,
    input  logic               arready,
    input  mem_pkg::axi_r_t    r,
    input  logic               rvalid,
    output logic               rready,
    output mem_pkg::axi_aw_t   aw,
    output logic               awvalid,
    input  logic               awready,
    output mem_pkg::axi_w_t    w,
    output logic               wvalid,
    input  logic               wready,
    input  mem_pkg::axi_b_t    b,
    input  logic               bvalid,
    output logic               bready
);
    import mem_pkg::*;

    // refill link between the icache and the arbiter.
    logic        refill_req;
    addr_t       refill_addr;
    logic        refill_beat_valid;
    logic        refill_done;
    logic        refill_fault;
    word_t       refill_beat;

    logic        clint_rd;
    logic [15:0] clint_offset;
    logic        clint_rvalid;
    word_t       clint_rdata;

    icache #(
        .cache_blocks (cache_blocks),
        .block_bytes  (block_bytes)
    ) u_icache (
        .clock             (clock),
        .arst_n            (arst_n),
        .fetch_valid       (fetch_valid),
        .fetch_addr        (fetch_addr),
        .fetch_ready       (fetch_ready),
        .fetch_resp_valid  (fetch_resp_valid),
        .fetch_fault       (fetch_fault),
        .fetch_data        (fetch_data),
        .flush             (icache_flush),
        .refill_req        (refill_req),
        .refill_addr       (refill_addr),
        .refill_beat_valid (refill_beat_valid),
        .refill_done       (refill_done),
        .refill_fault      (refill_fault),
        .refill_beat       (refill_beat)
    );

    mem_arbiter #(
        .block_bytes (block_bytes)
    ) u_arbiter (
        .clock             (clock),
        .arst_n            (arst_n),
        .data_valid        (data_valid),
        .data_req          (data_req),
        .data_ready        (data_ready),
        .data_resp_valid   (data_resp_valid),
        .data_fault        (data_fault),
        .data_rdata        (data_rdata),
        .refill_req        (refill_req),
        .refill_addr       (refill_addr),
        .refill_beat_valid (refill_beat_valid),
        .refill_done       (refill_done),
        .refill_fault      (refill_fault),
        .refill_beat       (refill_beat),
        .clint_rd          (clint_rd),
        .clint_offset      (clint_offset),
        .clint_rvalid      (clint_rvalid),
        .clint_rdata       (clint_rdata),
        .ar                (ar),
        .arvalid           (arvalid),
        .arready           (arready),
        .r                 (r),
        .rvalid            (rvalid),
        .rready            (rready),
        .aw                (aw),
        .awvalid           (awvalid),
        .awready           (awready),
        .w                 (w),
        .wvalid            (wvalid),
        .wready            (wready),
        .b                 (b),
        .bvalid            (bvalid),
        .bready            (bready)
    );

    clint u_clint (
        .clock  (clock),
        .arst_n (arst_n),
        .rd     (clint_rd),
        .offset (clint_offset),
        .rvalid (clint_rvalid),
        .rdata  (clint_rdata)
    );

endmodule

//--- test/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
    input  logic             clock,
    input  logic             arst_n,
    input  mem_pkg::axi_ar_t ar,
    input  logic             arvalid,
    output logic             arready,
    output mem_pkg::axi_r_t  r,
    output logic             rvalid,
    input  logic             rready,
    input  mem_pkg::axi_aw_t aw,
    input  logic             awvalid,
    output logic             awready,
    input  mem_pkg::axi_w_t  w,
    input  logic             wvalid,
    output logic             wready,
    output mem_pkg::axi_b_t  b,
    output logic             bvalid,
    input  logic             bready,
    output int               ar_count
);
    import mem_pkg::*;

    localparam logic [1:0] resp_slverr = 2'b10;

    word_t      mem [logic [29:0]];  // only words that were written are stored.
    addr_t      rd_addr;
    logic [8:0] rd_left;
    logic [3:0] rd_id;
    addr_t      wr_addr;
    logic [3:0] wr_id;
    word_t      wr_data;
    logic [3:0] wr_strb;
    logic       aw_got;
    logic       w_got;

    function automatic logic in_error(input addr_t addr);
        return addr[31:24] == 8'h8F;
    endfunction

    // unwritten words hold their byte address XOR a fixed pattern.
    function automatic word_t read_word(input addr_t addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    always @(posedge clock or negedge arst_n) begin : model
        word_t merged;
        if (!arst_n) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            r        <= '0;
            b        <= '0;
            ar_count <= 0;
            rd_left  <= '0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
        end else begin
            arready <= ($urandom % 4) != 0;  // random back-pressure.
            awready <= ($urandom % 3) != 0;
            wready  <= ($urandom % 3) != 0;

            // ##############################
            // read bursts
            // ##############################
            if (arvalid && arready) begin
                rd_addr  <= ar.addr;
                rd_left  <= {1'b0, ar.len} + 9'd1;
                rd_id    <= ar.id;
                ar_count <= ar_count + 1;
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_addr <= rd_addr + 32'd4;
                rd_left <= rd_left - 9'd1;
            end else if (!rvalid && rd_left != 9'd0 && ($urandom % 3) != 0) begin
                rvalid <= 1'b1;
                r      <= '{data: read_word(rd_addr),
                            resp: in_error(rd_addr) ? resp_slverr : resp_okay,
                            last: rd_left == 9'd1,
                            id:   rd_id};
            end

            // ##############################
            // single-beat writes
            // ##############################
            if (awvalid && awready) begin
                wr_addr <= aw.addr;
                wr_id   <= aw.id;
                aw_got  <= 1'b1;
            end
            if (wvalid && wready) begin
                wr_data <= w.data;
                wr_strb <= w.strb;
                w_got   <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (aw_got && w_got && !bvalid && ($urandom % 2) != 0) begin
                merged = read_word(wr_addr);
                for (int i = 0; i < 4; i++) begin
                    if (wr_strb[i]) begin
                        merged[8*i +: 8] = wr_data[8*i +: 8];
                    end
                end
                if (!in_error(wr_addr)) begin
                    mem[wr_addr[31:2]] = merged;  // the error region ignores writes.
                end
                b      <= '{resp: in_error(wr_addr) ? resp_slverr : resp_okay, id: wr_id};
                bvalid <= 1'b1;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end
        end
    end

endmodule

//--- test/tb_core_mem_system.sv
`timescale 1ns/1ps

module tb_core_mem_system;
    import mem_pkg::*;

    localparam int    block_bytes  = 16;
    localparam int    accept_limit = 50;
    localparam int    resp_limit   = 300;
    localparam addr_t err_base     = 32'h8F00_0000;

    logic      clock = 1'b0;
    logic      arst_n;
    logic      fetch_valid, fetch_ready, fetch_resp_valid, fetch_fault, icache_flush;
    addr_t     fetch_addr;
    word_t     fetch_data;
    logic      data_valid, data_ready, data_resp_valid, data_fault;
    dmem_req_t data_req;
    word_t     data_rdata;
    axi_ar_t   ar;
    axi_r_t    r;
    axi_aw_t   aw;
    axi_w_t    w;
    axi_b_t    b;
    logic      arvalid, arready, rvalid, rready, awvalid, awready;
    logic      wvalid, wready, bvalid, bready;
    int        ar_count;
    int        cycle_count = 0;
    axi_ar_t   ar_seen [$];

    core_mem_system #(
        .cache_blocks (16),
        .block_bytes  (block_bytes)
    ) dut (.*);

    axi_mem_model mem_model (.*);

    always #20 clock = ~clock;

    // AR handshakes are logged mid-cycle, where the channel signals are settled.
    always @(negedge clock) begin
        cycle_count <= cycle_count + 1;
        if (arst_n && arvalid && arready) begin
            ar_seen.push_back(ar);
        end
    end

    function automatic word_t fill_word(input addr_t addr);
        return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t wdata,
                                          input logic [3:0] strb);
        word_t merged;
        merged = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return merged;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else fail_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic check_at_least(input string name, input int minimum, input int actual);
        assert (actual >= minimum)
        else fail_run($sformatf("Fail %s: expected at least %0d, actual %0d",
                                name, minimum, actual));
    endtask

    // both ports are entered just after a rising edge and left on the response edge.
    task automatic fetch(input string name, input addr_t addr, output word_t data,
                         output logic fault, output int lat);
        int waited;
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (waited > accept_limit) begin
                fail_run({name, ": the fetch request was never accepted"});
            end
        end while (!fetch_ready);
        fetch_valid <= 1'b0;
        lat = 0;
        do begin
            @(posedge clock);
            lat++;
            if (lat > resp_limit) begin
                fail_run({name, ": no fetch response arrived"});
            end
        end while (!fetch_resp_valid);
        data  = fetch_data;
        fault = fetch_fault;
    endtask

    task automatic data_access(input string name, input dmem_req_t req, output word_t data,
                               output logic fault, output int lat, output int accept_cycle);
        int waited;
        data_valid <= 1'b1;
        data_req   <= req;
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (waited > accept_limit) begin
                fail_run({name, ": the data request was never accepted"});
            end
        end while (!data_ready);
        accept_cycle = cycle_count;
        data_valid <= 1'b0;
        lat = 0;
        do begin
            @(posedge clock);
            lat++;
            if (lat > resp_limit) begin
                fail_run({name, ": no data response arrived"});
            end
        end while (!data_resp_valid);
        data  = data_rdata;
        fault = data_fault;
    endtask

    initial begin
        word_t      data, data2, wdata;
        logic       fault, fault2;
        int         lat, lat2, cyc, cyc2, base_count, seen;
        addr_t      line_a, store_a;
        logic [3:0] strb;
        dmem_req_t  req;

        void'($urandom(32'h5f02_fb4a));
        arst_n       = 1'b0;
        fetch_valid  = 1'b0;
        fetch_addr   = '0;
        icache_flush = 1'b0;
        data_valid   = 1'b0;
        data_req     = '0;
        repeat (8) @(posedge clock);
        check_value("reset_outputs", 32'b110_0000, 32'({fetch_ready, data_ready,
                    fetch_resp_valid, data_resp_valid, arvalid, awvalid, wvalid}));
        arst_n <= 1'b1;
        @(posedge clock);

        // ##############################
        // icache miss, hits and flush
        // ##############################
        line_a     = 32'h0000_1000;
        base_count = ar_count;
        fetch("miss", line_a + 32'd4, data, fault, lat);
        check_value("miss_data", fill_word(line_a + 32'd4), data);
        check_value("miss_fault", 32'd0, 32'(fault));
        check_value("miss_ar_count", base_count + 1, ar_count);
        check_value("miss_ar_addr", line_a, ar_seen[$].addr);
        check_value("miss_ar_len", block_bytes / 4 - 1, 32'(ar_seen[$].len));
        for (int k = 0; k < block_bytes / 4; k++) begin
            fetch("hit", line_a + 32'(4 * k), data, fault, lat);
            check_value("hit_data", fill_word(line_a + 32'(4 * k)), data);
            check_value("hit_latency", 32'd1, lat);
        end
        check_value("hit_ar_count", base_count + 1, ar_count);

        icache_flush <= 1'b1;
        @(posedge clock);
        icache_flush <= 1'b0;
        fetch("flush", line_a + 32'd8, data, fault, lat);
        check_value("flush_data", fill_word(line_a + 32'd8), data);
        check_value("flush_ar_count", base_count + 2, ar_count);

        // ##############################
        // data port, faults and CLINT
        // ##############################
        store_a = 32'h0001_0000 + (($urandom % 256) << 2);
        strb    = 4'($urandom % 16);
        wdata   = $urandom;
        req     = '{addr: store_a, wdata: wdata, wstrb: strb, write: 1'b1};
        data_access("store", req, data, fault, lat, cyc);
        check_value("store_fault", 32'd0, 32'(fault));
        req.write = 1'b0;
        data_access("load", req, data, fault, lat, cyc);
        check_value("load_data", merge_bytes(fill_word(store_a), wdata, strb), data);
        check_value("load_fault", 32'd0, 32'(fault));

        req = '{addr: err_base + 32'h40, wdata: '0, wstrb: '0, write: 1'b0};
        data_access("error_load", req, data, fault, lat, cyc);
        check_value("error_load_fault", 32'd1, 32'(fault));
        base_count = ar_count;
        fetch("error_fetch", err_base + 32'h1000, data, fault, lat);
        check_value("error_fetch_fault", 32'd1, 32'(fault));
        fetch("error_refetch", err_base + 32'h1000, data, fault, lat);
        check_value("error_refetch_ar_count", base_count + 2, ar_count);

        base_count = ar_count;
        req = '{addr: clint_base + 32'(mtime_lo_offset), wdata: '0, wstrb: '0, write: 1'b0};
        data_access("clint_first", req, data, fault, lat, cyc);
        check_value("clint_first_latency", 32'd2, lat);
        data_access("clint_second", req, data2, fault, lat, cyc2);
        check_value("clint_second_latency", 32'd2, lat);
        check_at_least("clint_increase", cyc2 - cyc, int'(data2 - data));
        check_value("clint_ar_count", base_count, ar_count);

        // the load reaches the arbiter in the cycle the refill request rises, and wins.
        seen = ar_seen.size();
        req  = '{addr: 32'h0000_4010, wdata: '0, wstrb: '0, write: 1'b0};
        fork
            fetch("contend_fetch", 32'h0000_3004, data, fault, lat);
            begin
                repeat (2) @(posedge clock);  // acceptance, then the lookup miss.
                data_access("contend_load", req, data2, fault2, lat2, cyc);
            end
        join
        check_value("contend_fetch_data", fill_word(32'h0000_3004), data);
        check_value("contend_fetch_fault", 32'd0, 32'(fault));
        check_value("contend_load_data", fill_word(32'h0000_4010), data2);
        check_value("contend_load_fault", 32'd0, 32'(fault2));
        check_value("contend_ar_total", seen + 2, ar_seen.size());
        check_value("contend_first_ar", 32'h0000_4010, ar_seen[seen].addr);
        check_value("contend_second_ar", 32'h0000_3000, ar_seen[seen + 1].addr);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- src.f
verilog/mem_pkg.sv
verilog/icache.sv
verilog/mem_arbiter.sv
verilog/clint.sv
verilog/core_mem_system.sv
test/axi_mem_model.sv
test/tb_core_mem_system.sv

//--- Makefile
# Verilator build for the memory subsystem testbench.

VERILATOR ?= verilator
TOP       ?= tb_core_mem_system
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary exits with a failing status when the testbench stops on $$fatal.
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(OBJ_DIR)
